/* compile.f */
logic/rv_pkg.sv
logic/fetch_unit.sv
logic/control_decoder.sv
logic/register_file.sv
logic/execute_unit.sv
logic/data_memory.sv
logic/cpu_core.sv
dv/cpu_core_asserts.sv
dv/cpu_core_tb.sv

/* dv/cpu_core_asserts.sv */
/*
 Concurrent checks on cpu_core, bound into every instance.
 Fetch order is checked from the second cycle after reset on.
*/
`default_nettype none

module cpu_core_asserts (
    input  wire                     sysclk,
    input  wire                     reset,
    input  wire                     wb_valid,
    input  wire rv_pkg::reg_addr_t  wb_rd,
    input  wire rv_pkg::imem_addr_t imem_addr,
    input  wire                     redirect,
    input  wire rv_pkg::pc_t        redirect_pc
);

    int error_count = 0;

    a_wb_rd_nonzero: assert property (
        @(posedge sysclk) disable iff (reset) wb_valid |-> wb_rd != '0
    ) else
    begin
        error_count++;
        $error("wb_valid high with wb_rd zero");
    end

    a_no_wb_in_reset: assert property (
        @(posedge sysclk) reset && $past(reset) |-> !wb_valid
    ) else
    begin
        error_count++;
        $error("wb_valid high during reset");
    end

    // Next word in sequence, counted from the target in the cycle after a redirect
    a_fetch_order: assert property (
        @(posedge sysclk) disable iff (reset)
        !$past(reset) && !redirect |->
            imem_addr == rv_pkg::imem_addr_t'(($past(redirect)
                ? $past(redirect_pc[rv_pkg::PC_WIDTH-1:2]) : $past(imem_addr)) + 1'b1)
    ) else
    begin
        error_count++;
        $error("imem_addr did not advance by one word from the last fetch or redirect target");
    end

endmodule

bind cpu_core cpu_core_asserts u_asserts (
    .sysclk      (sysclk),
    .reset       (reset),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .imem_addr   (imem_addr),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
);

`default_nettype wire

/* dv/cpu_core_tb.sv */
/*
 Testbench for cpu_core. Instruction memory is a synchronous-read model that is
 filled with ADDI x0 no-ops. The program and its expected register writes are
 built at time zero, and every write on wb_valid is checked in program order.
*/
`default_nettype none

module cpu_core_tb;

    logic sysclk;
    logic reset;
    rv_pkg::word_t imem_data;
    rv_pkg::imem_addr_t imem_addr;
    logic wb_valid;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::word_t wb_data;

    rv_pkg::word_t imem [2**(rv_pkg::PC_WIDTH-2)];
    rv_pkg::reg_addr_t exp_rd [$];
    rv_pkg::word_t exp_data [$];
    int prog_len;
    int watchdog_cycles;

    cpu_core DUT (
        .sysclk    (sysclk),
        .reset     (reset),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    initial
    begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    // Synchronous read with one cycle of latency
    always @(posedge sysclk)
    begin
        imem_data <= imem[imem_addr];
    end

    function automatic rv_pkg::word_t r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                             input int rd, input int rs1, input int rs2);
        return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], rv_pkg::OP_R};
    endfunction

    function automatic rv_pkg::word_t i_type(input logic [6:0] opcode, input logic [2:0] funct3,
                                             input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], funct3, rd[4:0], opcode};
    endfunction

    function automatic rv_pkg::word_t store_word(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], rv_pkg::F3_WORD, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic rv_pkg::word_t branch_word(input logic [2:0] funct3, input int rs1,
                                                  input int rs2, input int offset);
        return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], funct3, offset[4:1], offset[11],
                rv_pkg::OP_BRANCH};
    endfunction

    function automatic rv_pkg::word_t lui_word(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], rv_pkg::OP_LUI};
    endfunction

    function automatic rv_pkg::word_t jal_word(input int rd, input int offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], rv_pkg::OP_JAL};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic place(input rv_pkg::word_t instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    task automatic place_and_expect(input rv_pkg::word_t instr, input int rd,
                                    input rv_pkg::word_t data);
        place(instr);
        exp_rd.push_back(rd[4:0]);
        exp_data.push_back(data);
    endtask

    // Cancelled slots that would otherwise write x31
    task automatic shadow_pair();
        place(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 31, 0, 'h7ff));
        place(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 31, 0, 'h7ff));
    endtask

    task automatic check_value(input string name, input rv_pkg::word_t expected,
                               input rv_pkg::word_t actual);
        if (actual !== expected)
        begin
            $display("FAIL %s expected 0x%08h got 0x%08h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic build_program();
        logic [31:0] rng;
        logic [11:0] imm12;
        rv_pkg::word_t acc;
        int jal_pc;
        rng = 32'd61297;
        acc = '0;
        // ADDI x0 fill whose rs1 and immediate follow the word address
        for (int i = 0; i < 2**(rv_pkg::PC_WIDTH-2); i++)
            imem[i] = i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 0, i >> 12, i & 'hfff);

        // ALU with ME and WB bypass
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 1, 0, 5), 1, 32'h5);
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 2, 1, -3), 2, 32'h2);
        place_and_expect(r_type(7'h00, rv_pkg::F3_ADD, 3, 1, 2), 3, 32'h7);
        place_and_expect(r_type(7'h20, rv_pkg::F3_ADD, 4, 3, 1), 4, 32'h2);
        place_and_expect(lui_word(5, 'h80000), 5, 32'h8000_0000);
        place_and_expect(r_type(7'h20, rv_pkg::F3_SR, 6, 5, 2), 6, 32'he000_0000);
        place_and_expect(r_type(7'h00, rv_pkg::F3_SR, 7, 5, 2), 7, 32'h2000_0000);
        place_and_expect(r_type(7'h00, rv_pkg::F3_SLL, 8, 1, 4), 8, 32'h14);
        place_and_expect(r_type(7'h00, rv_pkg::F3_XOR, 9, 6, 7), 9, 32'hc000_0000);
        place_and_expect(r_type(7'h00, rv_pkg::F3_OR, 10, 1, 2), 10, 32'h7);
        place_and_expect(r_type(7'h00, 3'b111, 11, 3, 1), 11, 32'h5);
        place_and_expect(r_type(7'h00, rv_pkg::F3_SLT, 12, 5, 1), 12, 32'h1);
        place_and_expect(r_type(7'h00, rv_pkg::F3_SLTU, 13, 5, 1), 13, 32'h0);
        place_and_expect(r_type(7'h00, rv_pkg::F3_SLTU, 14, 1, 5), 14, 32'h1);
        place_and_expect(r_type(7'h00, rv_pkg::F3_SLT, 15, 1, 5), 15, 32'h0);
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_XOR, 16, 1, -1),
                         16, 32'hffff_fffa);
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_OR, 17, 1, 'hf0), 17, 32'hf5);
        place_and_expect(i_type(rv_pkg::OP_IMM, 3'b111, 18, 16, 'hff), 18, 32'hfa);
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_SLT, 19, 16, 0), 19, 32'h1);
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_SLTU, 20, 1, -1), 20, 32'h1);
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_SLL, 21, 1, 4), 21, 32'h50);
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_SR, 22, 16, 28), 22, 32'hf);
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_SR, 23, 16, 'h401),
                         23, 32'hffff_fffd);

        // x0 is never written and never bypassed
        place(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 0, 1, 99));
        place_and_expect(r_type(7'h00, rv_pkg::F3_ADD, 24, 0, 1), 24, 32'h5);

        // Store, load, and use of the load result right after it
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 25, 0, 'h40), 25, 32'h40);
        place(store_word(9, 25, 8));
        place(store_word(16, 25, 12));
        place_and_expect(i_type(rv_pkg::OP_LOAD, rv_pkg::F3_WORD, 26, 25, 8),
                         26, 32'hc000_0000);
        place_and_expect(r_type(7'h00, rv_pkg::F3_ADD, 27, 26, 1), 27, 32'hc000_0005);
        place_and_expect(i_type(rv_pkg::OP_LOAD, rv_pkg::F3_WORD, 28, 25, 12),
                         28, 32'hffff_fffa);
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 29, 28, 7), 29, 32'h1);

        // Taken branches skip two slots
        place(branch_word(rv_pkg::F3_BEQ, 1, 11, 12));
        shadow_pair();
        place(branch_word(rv_pkg::F3_BNE, 1, 2, 12));
        shadow_pair();
        place(branch_word(rv_pkg::F3_BLT, 5, 1, 12));
        shadow_pair();
        place(branch_word(rv_pkg::F3_BGE, 1, 5, 12));
        shadow_pair();

        // Not-taken branches fall through into an ADDI
        place(branch_word(rv_pkg::F3_BEQ, 1, 2, 12));
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 30, 0, 1), 30, 32'h1);
        place(branch_word(rv_pkg::F3_BNE, 1, 11, 8));
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 30, 30, 2), 30, 32'h3);
        place(branch_word(rv_pkg::F3_BLT, 1, 5, 8));
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 30, 30, 4), 30, 32'h7);
        place(branch_word(rv_pkg::F3_BGE, 5, 1, 8));
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 30, 30, 8), 30, 32'hf);

        // JAL links its own address plus 4
        jal_pc = prog_len * 4;
        place_and_expect(jal_word(31, 12), 31, rv_pkg::word_t'(jal_pc + 4));
        shadow_pair();
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 30, 31, 1),
                         30, rv_pkg::word_t'(jal_pc + 5));

        // Branch taken only when x2 comes from the ME bypass
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 2, 0, 5), 2, 32'h5);
        place(branch_word(rv_pkg::F3_BEQ, 2, 1, 12));
        shadow_pair();

        // Random ADDI chain into x3
        place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 3, 0, 0), 3, 32'h0);
        for (int k = 0; k < 16; k++)
        begin
            rng = xorshift(rng);
            imm12 = rng[11:0];
            acc = acc + {{20{imm12[11]}}, imm12};
            place_and_expect(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 3, 3, int'(imm12)), 3, acc);
        end
    endtask

    initial
    begin
        reset = 1'b1;
        imem_data = '0;
        prog_len = 0;
        build_program();
        watchdog_cycles = exp_rd.size() * 20 + 8;

        fork
            begin
                repeat (watchdog_cycles) @(posedge sysclk);
                $display("Timeout, not all expected register writes arrived in time");
                $display("*** TEST FAILED ***");
                $fatal(1, "Watchdog expired");
            end
            begin
                wait (DUT.u_asserts.error_count != 0);
                $display("An assertion bound into cpu_core failed");
                $display("*** TEST FAILED ***");
                $fatal(1, "Assertion failure");
            end
        join_none

        repeat (8) @(posedge sysclk);
        reset <= 1'b0;

        @(negedge sysclk);
        check_value("imem_addr", '0, rv_pkg::word_t'(imem_addr));
        check_value("wb_valid", '0, rv_pkg::word_t'(wb_valid));
        @(negedge sysclk);
        check_value("imem_addr", 32'h1, rv_pkg::word_t'(imem_addr));

        for (int i = 0; i < exp_rd.size(); i++)
        begin
            @(negedge sysclk);
            while (!wb_valid)
                @(negedge sysclk);
            check_value("wb_rd", rv_pkg::word_t'(exp_rd[i]), rv_pkg::word_t'(wb_rd));
            check_value("wb_data", exp_data[i], wb_data);
        end

        // The x0 fill after the program never retires
        repeat (10)
        begin
            @(negedge sysclk);
            check_value("wb_valid", '0, rv_pkg::word_t'(wb_valid));
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/control_decoder.sv */
/*
 Instruction decode for the kept RV32I subset. Any other opcode, and loads,
 stores or branches with an unsupported funct3, decode with all enables low.
*/
`default_nettype none

module control_decoder (
    input  wire rv_pkg::word_t  instr,
    output rv_pkg::reg_addr_t   rs1,
    output rv_pkg::reg_addr_t   rs2,
    output rv_pkg::reg_addr_t   rd,
    output rv_pkg::word_t       imm,
    output rv_pkg::alu_op_e     alu_op,
    output logic                use_imm,
    output logic                reg_write,
    output logic                mem_read,
    output logic                mem_write,
    output logic                is_branch,
    output logic                is_jal,
    output logic [2:0]          branch_funct,
    output rv_pkg::wb_sel_e     wb_sel
);

    rv_pkg::opcode_e opcode;
    rv_pkg::alu_op_e arith_op;
    logic [2:0] funct3;

    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd = instr[11:7];
    assign branch_funct = funct3;

    // instr[30] picks SUB (register form only) and SRA
    always_comb
    begin
        case (funct3)
            rv_pkg::F3_ADD:
                arith_op = (opcode == rv_pkg::OP_R && instr[30]) ? rv_pkg::ALU_SUB
                                                                 : rv_pkg::ALU_ADD;
            rv_pkg::F3_SLL:  arith_op = rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT:  arith_op = rv_pkg::ALU_SLT;
            rv_pkg::F3_SLTU: arith_op = rv_pkg::ALU_SLTU;
            rv_pkg::F3_XOR:  arith_op = rv_pkg::ALU_XOR;
            rv_pkg::F3_SR:   arith_op = instr[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:   arith_op = rv_pkg::ALU_OR;
            default:         arith_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb
    begin
        imm = '0;
        alu_op = rv_pkg::ALU_ADD;
        use_imm = 1'b0;
        reg_write = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        is_branch = 1'b0;
        is_jal = 1'b0;
        wb_sel = rv_pkg::WB_ALU;

        case (opcode)
            rv_pkg::OP_R:
            begin
                alu_op = arith_op;
                reg_write = 1'b1;
            end
            rv_pkg::OP_IMM:
            begin
                imm = {{20{instr[31]}}, instr[31:20]};
                alu_op = arith_op;
                use_imm = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::OP_LUI:
            begin
                imm = {instr[31:12], 12'b0};
                alu_op = rv_pkg::ALU_PASS_B;
                use_imm = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::OP_LOAD:
            begin
                imm = {{20{instr[31]}}, instr[31:20]};
                use_imm = 1'b1;
                reg_write = (funct3 == rv_pkg::F3_WORD);
                mem_read = (funct3 == rv_pkg::F3_WORD);
                wb_sel = rv_pkg::WB_MEM;
            end
            rv_pkg::OP_STORE:
            begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                use_imm = 1'b1;
                mem_write = (funct3 == rv_pkg::F3_WORD);
            end
            rv_pkg::OP_BRANCH:
            begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                is_branch = (funct3 == rv_pkg::F3_BEQ) || (funct3 == rv_pkg::F3_BNE)
                         || (funct3 == rv_pkg::F3_BLT) || (funct3 == rv_pkg::F3_BGE);
            end
            rv_pkg::OP_JAL:
            begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
                is_jal = 1'b1;
                reg_write = 1'b1;
                wb_sel = rv_pkg::WB_PC_PLUS4;
            end
            default:
            begin
                // No-op
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/cpu_core.sv */
/*
 Five-stage RV32I subset core, no stalls. Taken branches and JAL resolve in
 EX and cancel the two younger instructions. Each register write shows up
 on wb_valid, wb_rd and wb_data, four cycles after the word is on imem_data.
*/
`default_nettype none

module cpu_core (
    input  wire                 sysclk,
    input  wire                 reset,
    input  wire rv_pkg::word_t  imem_data,
    output rv_pkg::imem_addr_t  imem_addr,
    output logic                wb_valid,
    output rv_pkg::reg_addr_t   wb_rd,
    output rv_pkg::word_t       wb_data
);

    // IF
    logic fetch_valid;
    rv_pkg::pc_t if_pc;

    // ID
    logic id_valid;
    rv_pkg::word_t id_instr;
    rv_pkg::pc_t id_pc;
    rv_pkg::reg_addr_t dec_rs1, dec_rs2, dec_rd;
    rv_pkg::word_t dec_imm, rf_rdata1, rf_rdata2;
    rv_pkg::alu_op_e dec_alu_op;
    logic dec_use_imm, dec_reg_write, dec_mem_read, dec_mem_write;
    logic dec_is_branch, dec_is_jal;
    logic [2:0] dec_branch_funct;
    rv_pkg::wb_sel_e dec_wb_sel;

    // EX
    logic ex_valid;
    rv_pkg::pc_t ex_pc;
    rv_pkg::reg_addr_t ex_rs1, ex_rs2, ex_rd;
    rv_pkg::word_t ex_rs1_data, ex_rs2_data, ex_imm;
    rv_pkg::alu_op_e ex_alu_op;
    logic ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write;
    logic ex_is_branch, ex_is_jal;
    logic [2:0] ex_branch_funct;
    rv_pkg::wb_sel_e ex_wb_sel;
    rv_pkg::word_t alu_result, store_data;
    logic redirect;
    rv_pkg::pc_t redirect_pc;

    // ME
    logic me_valid;
    rv_pkg::pc_t me_pc;
    rv_pkg::reg_addr_t me_rd;
    logic me_reg_write, me_mem_read, me_mem_write;
    rv_pkg::wb_sel_e me_wb_sel;
    rv_pkg::word_t me_alu_result, me_store_data, dmem_rdata, me_result;
    logic me_fwd_valid;

    fetch_unit u_fetch (
        .sysclk      (sysclk),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (if_pc),
        .imem_addr   (imem_addr)
    );

    control_decoder u_decoder (
        .instr        (id_instr),
        .rs1          (dec_rs1),
        .rs2          (dec_rs2),
        .rd           (dec_rd),
        .imm          (dec_imm),
        .alu_op       (dec_alu_op),
        .use_imm      (dec_use_imm),
        .reg_write    (dec_reg_write),
        .mem_read     (dec_mem_read),
        .mem_write    (dec_mem_write),
        .is_branch    (dec_is_branch),
        .is_jal       (dec_is_jal),
        .branch_funct (dec_branch_funct),
        .wb_sel       (dec_wb_sel)
    );

    // Read in ID, writes come from WB
    register_file u_regs (
        .sysclk (sysclk),
        .reset  (reset),
        .we     (wb_valid),
        .waddr  (wb_rd),
        .raddr1 (dec_rs1),
        .raddr2 (dec_rs2),
        .wdata  (wb_data),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    execute_unit u_execute (
        .valid        (ex_valid),
        .pc           (ex_pc),
        .rs1          (ex_rs1),
        .rs2          (ex_rs2),
        .rs1_data     (ex_rs1_data),
        .rs2_data     (ex_rs2_data),
        .imm          (ex_imm),
        .alu_op       (ex_alu_op),
        .use_imm      (ex_use_imm),
        .is_branch    (ex_is_branch),
        .is_jal       (ex_is_jal),
        .branch_funct (ex_branch_funct),
        .me_fwd_valid (me_fwd_valid),
        .me_rd        (me_rd),
        .me_data      (me_result),
        .wb_fwd_valid (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .alu_result   (alu_result),
        .store_data   (store_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    data_memory u_dmem (
        .sysclk (sysclk),
        .we     (me_valid && me_mem_write),
        .addr   (me_alu_result[rv_pkg::DMEM_ADDR_WIDTH+1:2]),
        .wdata  (me_store_data),
        .rdata  (dmem_rdata)
    );

    // Load data is ready in ME, so it bypasses like any other result
    always_comb
    begin
        if (me_mem_read)
            me_result = dmem_rdata;
        else if (me_wb_sel == rv_pkg::WB_PC_PLUS4)
            me_result = rv_pkg::word_t'(me_pc + rv_pkg::pc_t'(4));
        else
            me_result = me_alu_result;
    end

    assign me_fwd_valid = me_valid && me_reg_write;

    always_ff @(posedge sysclk)
    begin
        if (reset)
        begin
            fetch_valid <= 1'b0;
            id_valid <= 1'b0;
            ex_valid <= 1'b0;
            me_valid <= 1'b0;
            wb_valid <= 1'b0;
        end
        else
        begin
            fetch_valid <= 1'b1;
            // Redirect drops the words now in IF and ID
            id_valid <= fetch_valid && !redirect;
            ex_valid <= id_valid && !redirect;
            me_valid <= ex_valid;
            wb_valid <= me_fwd_valid && me_rd != '0;
        end
    end

    always_ff @(posedge sysclk)
    begin
        id_instr <= imem_data;
        id_pc <= if_pc;

        ex_pc <= id_pc;
        ex_rs1 <= dec_rs1;
        ex_rs2 <= dec_rs2;
        ex_rd <= dec_rd;
        ex_rs1_data <= rf_rdata1;
        ex_rs2_data <= rf_rdata2;
        ex_imm <= dec_imm;
        ex_alu_op <= dec_alu_op;
        ex_use_imm <= dec_use_imm;
        ex_reg_write <= dec_reg_write;
        ex_mem_read <= dec_mem_read;
        ex_mem_write <= dec_mem_write;
        ex_is_branch <= dec_is_branch;
        ex_is_jal <= dec_is_jal;
        ex_branch_funct <= dec_branch_funct;
        ex_wb_sel <= dec_wb_sel;

        me_pc <= ex_pc;
        me_rd <= ex_rd;
        me_reg_write <= ex_reg_write;
        me_mem_read <= ex_mem_read;
        me_mem_write <= ex_mem_write;
        me_wb_sel <= ex_wb_sel;
        me_alu_result <= alu_result;
        me_store_data <= store_data;

        wb_rd <= me_rd;
        wb_data <= me_result;
    end

endmodule

`default_nettype wire

/* logic/data_memory.sv */
/*
 256-word data RAM with combinational read and write on sysclk.
 Contents are undefined until written.
*/
`default_nettype none

module data_memory (
    input  wire                     sysclk,
    input  wire                     we,
    input  wire rv_pkg::dmem_addr_t addr,
    input  wire rv_pkg::word_t      wdata,
    output rv_pkg::word_t           rdata
);

    rv_pkg::word_t mem [2**rv_pkg::DMEM_ADDR_WIDTH];

    assign rdata = mem[addr];

    always_ff @(posedge sysclk)
    begin
        if (we)
            mem[addr] <= wdata;
    end

endmodule

`default_nettype wire

/* logic/execute_unit.sv */
/*
 Execute stage logic. Operands bypass from ME first, then WB, then the
 register file. Branch and JAL targets are pc plus the immediate.
*/
`default_nettype none

module execute_unit (
    input  wire                     valid,
    input  wire rv_pkg::pc_t        pc,
    input  wire rv_pkg::reg_addr_t  rs1,
    input  wire rv_pkg::reg_addr_t  rs2,
    input  wire rv_pkg::word_t      rs1_data,
    input  wire rv_pkg::word_t      rs2_data,
    input  wire rv_pkg::word_t      imm,
    input  wire rv_pkg::alu_op_e    alu_op,
    input  wire                     use_imm,
    input  wire                     is_branch,
    input  wire                     is_jal,
    input  wire [2:0]               branch_funct,
    input  wire                     me_fwd_valid,
    input  wire rv_pkg::reg_addr_t  me_rd,
    input  wire rv_pkg::word_t      me_data,
    input  wire                     wb_fwd_valid,
    input  wire rv_pkg::reg_addr_t  wb_rd,
    input  wire rv_pkg::word_t      wb_data,
    output rv_pkg::word_t           alu_result,
    output rv_pkg::word_t           store_data,
    output logic                    redirect,
    output rv_pkg::pc_t             redirect_pc
);

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t rs2_value;
    logic taken;

    // Younger producer wins
    function automatic rv_pkg::word_t bypass(input rv_pkg::reg_addr_t rs,
                                             input rv_pkg::word_t rf_value);
        if (me_fwd_valid && me_rd == rs && rs != '0)
            return me_data;
        if (wb_fwd_valid && wb_rd == rs && rs != '0)
            return wb_data;
        return rf_value;
    endfunction

    always_comb
    begin
        op_a = bypass(rs1, rs1_data);
        rs2_value = bypass(rs2, rs2_data);
        op_b = use_imm ? imm : rs2_value;
    end

    assign store_data = rs2_value;

    always_comb
    begin
        case (alu_op)
            rv_pkg::ALU_ADD:  alu_result = op_a + op_b;
            rv_pkg::ALU_SUB:  alu_result = op_a - op_b;
            rv_pkg::ALU_AND:  alu_result = op_a & op_b;
            rv_pkg::ALU_OR:   alu_result = op_a | op_b;
            rv_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            rv_pkg::ALU_SLT:  alu_result = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
            rv_pkg::ALU_SLTU: alu_result = rv_pkg::word_t'(op_a < op_b);
            rv_pkg::ALU_SLL:  alu_result = op_a << op_b[4:0];
            rv_pkg::ALU_SRL:  alu_result = op_a >> op_b[4:0];
            rv_pkg::ALU_SRA:  alu_result = rv_pkg::word_t'($signed(op_a) >>> op_b[4:0]);
            default:          alu_result = op_b;
        endcase
    end

    // Branches always compare the two registers
    always_comb
    begin
        case (branch_funct)
            rv_pkg::F3_BEQ: taken = (op_a == rs2_value);
            rv_pkg::F3_BNE: taken = (op_a != rs2_value);
            rv_pkg::F3_BLT: taken = ($signed(op_a) < $signed(rs2_value));
            rv_pkg::F3_BGE: taken = ($signed(op_a) >= $signed(rs2_value));
            default:        taken = 1'b0;
        endcase
    end

    assign redirect = valid && (is_jal || (is_branch && taken));
    assign redirect_pc = pc + imm[rv_pkg::PC_WIDTH-1:0];

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
/*
 Program counter. imem_addr is the word address of the next pc, so the
 synchronous instruction memory returns the word for pc one cycle later.
*/
`default_nettype none

module fetch_unit (
    input  wire                 sysclk,
    input  wire                 reset,
    input  wire                 redirect,
    input  wire rv_pkg::pc_t    redirect_pc,
    output rv_pkg::pc_t         pc,
    output rv_pkg::imem_addr_t  imem_addr
);

    rv_pkg::pc_t next_pc;
    logic started;

    // First fetch after reset repeats address 0
    always_comb
    begin
        if (redirect)
            next_pc = redirect_pc;
        else if (started)
            next_pc = pc + rv_pkg::pc_t'(4);
        else
            next_pc = pc;
    end

    assign imem_addr = next_pc[rv_pkg::PC_WIDTH-1:2];

    always_ff @(posedge sysclk)
    begin
        if (reset)
        begin
            pc <= '0;
            started <= 1'b0;
        end
        else
        begin
            pc <= next_pc;
            started <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/register_file.sv */
/*
 32 x 32-bit register file, x0 reads as zero. A read of the register being
 written in the same cycle returns the new value.
*/
`default_nettype none

module register_file (
    input  wire                     sysclk,
    input  wire                     reset,
    input  wire                     we,
    input  wire rv_pkg::reg_addr_t  waddr,
    input  wire rv_pkg::reg_addr_t  raddr1,
    input  wire rv_pkg::reg_addr_t  raddr2,
    input  wire rv_pkg::word_t      wdata,
    output rv_pkg::word_t           rdata1,
    output rv_pkg::word_t           rdata2
);

    rv_pkg::word_t regs [32];

    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t raddr);
        if (we && waddr == raddr && raddr != '0)
            return wdata;
        return regs[raddr];
    endfunction

    always_comb
    begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

    // x0 is cleared by reset and never written
    always_ff @(posedge sysclk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && waddr != '0)
        begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_pkg.sv */
/*
 Shared widths, opcodes and control encodings for the RV32I subset core.
 Only word loads and stores are kept, and there are no CSRs, JALR or AUIPC.
*/
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;
    localparam int PC_WIDTH = 16;
    localparam int DMEM_ADDR_WIDTH = 8;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [PC_WIDTH-1:0] pc_t;
    typedef logic [PC_WIDTH-3:0] imem_addr_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_t;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // Branch conditions
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // Word access, the only load and store size
    localparam logic [2:0] F3_WORD = 3'b010;

    // Arithmetic funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC_PLUS4
    } wb_sel_e;

endpackage

`default_nettype wire
